/* frame_dma_top.f */
hw/frame_pkg.sv
hw/frame_mem.sv
hw/mem_arbiter.sv
hw/host_write_port.sv
hw/input_streamer.sv
hw/result_writer.sv
hw/host_read_port.sv
hw/frame_dma_top.sv
test/frame_dma_tb.sv

/* hw/frame_dma_top.sv */
`timescale 1ns/100ps

module frame_dma_top #(
  parameter int CHUNK_WORDS = frame_pkg::DEF_CHUNK_WORDS,
  parameter int OUT_CHUNKS  = frame_pkg::DEF_OUT_CHUNKS
) (
  input  logic              aclk,
  input  logic              aresetn,
  // host writes
  input  frame_pkg::word_t  wr_data,
  input  logic              wr_valid,
  output logic              wr_ready,
  // host reads
  input  frame_pkg::addr_t  rd_addr,
  input  logic              rd_valid,
  output logic              rd_ready,
  output frame_pkg::word_t  rd_data,
  output logic              rd_data_valid,
  // accelerator input stream
  output frame_pkg::word_t  in_data,
  output logic              in_valid,
  input  logic              in_ready,
  // accelerator output stream
  input  frame_pkg::word_t  out_data,
  input  logic              out_valid,
  output logic              out_ready,
  input  logic              img_buffered
);

  localparam int NC = frame_pkg::N_CLIENTS;

  logic             [NC-1:0] mem_req;
  logic             [NC-1:0] mem_we;
  frame_pkg::addr_t [NC-1:0] mem_addr;
  frame_pkg::word_t [NC-1:0] mem_wdata;
  logic             [NC-1:0] mem_ack;
  frame_pkg::word_t          mem_rdata;

  logic              ram_en;
  logic              ram_we;
  frame_pkg::addr_t  ram_addr;
  frame_pkg::word_t  ram_wdata;
  frame_pkg::word_t  ram_rdata;

  frame_pkg::count_t written_words;
  frame_pkg::count_t stored_words;

  // read-only clients carry no write data
  assign mem_wdata[1] = '0;
  assign mem_wdata[3] = '0;

  // ----------------------------------------
  // shared memory and arbiter
  // ----------------------------------------
  frame_mem frame_mem_i (
    .aclk  (aclk),
    .en    (ram_en),
    .we    (ram_we),
    .addr  (ram_addr),
    .wdata (ram_wdata),
    .rdata (ram_rdata)
  );

  mem_arbiter #(
    .N_CLIENTS (NC)
  ) mem_arbiter_i (
    .aclk      (aclk),
    .aresetn   (aresetn),
    .mem_req   (mem_req),
    .mem_we    (mem_we),
    .mem_addr  (mem_addr),
    .mem_wdata (mem_wdata),
    .mem_ack   (mem_ack),
    .mem_rdata (mem_rdata),
    .ram_en    (ram_en),
    .ram_we    (ram_we),
    .ram_addr  (ram_addr),
    .ram_wdata (ram_wdata),
    .ram_rdata (ram_rdata)
  );

  // ----------------------------------------
  // clients
  // ----------------------------------------
  host_write_port host_write_port_i (
    .aclk          (aclk),
    .aresetn       (aresetn),
    .wr_valid      (wr_valid),
    .wr_data       (wr_data),
    .wr_ready      (wr_ready),
    .written_words (written_words),
    .mem_req       (mem_req[0]),
    .mem_we        (mem_we[0]),
    .mem_addr      (mem_addr[0]),
    .mem_wdata     (mem_wdata[0]),
    .mem_ack       (mem_ack[0])
  );

  input_streamer #(
    .CHUNK_WORDS (CHUNK_WORDS)
  ) input_streamer_i (
    .aclk          (aclk),
    .aresetn       (aresetn),
    .written_words (written_words),
    .in_data       (in_data),
    .in_valid      (in_valid),
    .in_ready      (in_ready),
    .mem_req       (mem_req[1]),
    .mem_we        (mem_we[1]),
    .mem_addr      (mem_addr[1]),
    .mem_ack       (mem_ack[1]),
    .mem_rdata     (mem_rdata)
  );

  result_writer #(
    .CHUNK_WORDS (CHUNK_WORDS),
    .OUT_CHUNKS  (OUT_CHUNKS)
  ) result_writer_i (
    .aclk         (aclk),
    .aresetn      (aresetn),
    .img_buffered (img_buffered),
    .out_data     (out_data),
    .out_valid    (out_valid),
    .out_ready    (out_ready),
    .stored_words (stored_words),
    .mem_req      (mem_req[2]),
    .mem_we       (mem_we[2]),
    .mem_addr     (mem_addr[2]),
    .mem_wdata    (mem_wdata[2]),
    .mem_ack      (mem_ack[2])
  );

  host_read_port host_read_port_i (
    .aclk          (aclk),
    .aresetn       (aresetn),
    .rd_valid      (rd_valid),
    .rd_addr       (rd_addr),
    .rd_ready      (rd_ready),
    .rd_data       (rd_data),
    .rd_data_valid (rd_data_valid),
    .stored_words  (stored_words),
    .mem_req       (mem_req[3]),
    .mem_we        (mem_we[3]),
    .mem_addr      (mem_addr[3]),
    .mem_ack       (mem_ack[3]),
    .mem_rdata     (mem_rdata)
  );

endmodule

/* hw/frame_mem.sv */
`timescale 1ns/100ps

module frame_mem (
  input  logic              aclk,
  input  logic              en,
  input  logic              we,
  input  frame_pkg::addr_t  addr,
  input  frame_pkg::word_t  wdata,
  output frame_pkg::word_t  rdata
);

  localparam int DEPTH = 2 ** $bits(frame_pkg::addr_t);

  frame_pkg::word_t mem [DEPTH];

  // single port, read data registered one cycle after en
  always_ff @(posedge aclk) begin
    if (en) begin
      if (we) begin
        mem[addr] <= wdata;
      end
      rdata <= mem[addr];
    end
  end

endmodule

/* hw/frame_pkg.sv */
package frame_pkg;

  // ----------------------------------------
  // memory and stream word types
  // ----------------------------------------

  typedef logic [31:0] word_t;

  // 256 words of frame memory
  typedef logic [7:0] addr_t;

  // counts run up to a full region of 128 words
  typedef logic [8:0] count_t;

  // ----------------------------------------
  // memory map
  // ----------------------------------------

  // input image region, up to 128 words
  localparam addr_t IN_BASE = 8'd0;

  // result region sits right above the input region
  localparam addr_t OUT_BASE = 8'd128;

  // ----------------------------------------
  // defaults for the top level
  // ----------------------------------------

  localparam int N_CLIENTS = 4;
  localparam int DEF_CHUNK_WORDS = 16;
  localparam int DEF_OUT_CHUNKS = 2;

endpackage

/* hw/host_read_port.sv */
`timescale 1ns/100ps

module host_read_port (
  input  logic               aclk,
  input  logic               aresetn,
  input  logic               rd_valid,
  input  frame_pkg::addr_t   rd_addr,
  output logic               rd_ready,
  output frame_pkg::word_t   rd_data,
  output logic               rd_data_valid,
  input  frame_pkg::count_t  stored_words,
  output logic               mem_req,
  output logic               mem_we,
  output frame_pkg::addr_t   mem_addr,
  input  logic               mem_ack,
  input  frame_pkg::word_t   mem_rdata
);

  frame_pkg::addr_t addr_q;
  logic             word_stored;

  // offset within the result region
  assign word_stored = frame_pkg::count_t'(rd_addr) < stored_words;
  assign mem_we      = 1'b0;
  assign mem_addr    = frame_pkg::OUT_BASE + addr_q;

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      rd_ready      <= 1'b0;
      mem_req       <= 1'b0;
      rd_data_valid <= 1'b0;
    end else begin
      rd_data_valid <= 1'b0;
      if (rd_valid && rd_ready) begin
        mem_req  <= 1'b1;
        rd_ready <= 1'b0;
      end else if (rd_valid && word_stored && !rd_ready && !mem_req && !mem_ack) begin
        rd_ready <= 1'b1;
      end
      if (mem_req && mem_ack) begin
        mem_req       <= 1'b0;
        rd_data_valid <= 1'b1;
      end
    end
  end

  always_ff @(posedge aclk) begin
    if (rd_valid && rd_ready) begin
      addr_q <= rd_addr;
    end
    if (mem_req && mem_ack) begin
      rd_data <= mem_rdata;
    end
  end

endmodule

/* hw/host_write_port.sv */
`timescale 1ns/100ps

module host_write_port (
  input  logic               aclk,
  input  logic               aresetn,
  input  logic               wr_valid,
  input  frame_pkg::word_t   wr_data,
  output logic               wr_ready,
  output frame_pkg::count_t  written_words,
  output logic               mem_req,
  output logic               mem_we,
  output frame_pkg::addr_t   mem_addr,
  output frame_pkg::word_t   mem_wdata,
  input  logic               mem_ack
);

  // size of the input region in words
  localparam frame_pkg::count_t IN_WORDS =
    frame_pkg::count_t'(frame_pkg::OUT_BASE - frame_pkg::IN_BASE);

  logic room;

  assign room     = written_words < IN_WORDS;
  assign mem_we   = 1'b1;
  // count only moves on ack, after req has dropped
  assign mem_addr = frame_pkg::IN_BASE + written_words[7:0];

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      wr_ready      <= 1'b0;
      mem_req       <= 1'b0;
      written_words <= '0;
    end else begin
      if (wr_valid && wr_ready) begin
        mem_req  <= 1'b1;
        wr_ready <= 1'b0;
      end else if (!wr_ready && !mem_req && !mem_ack && room) begin
        wr_ready <= 1'b1;
      end
      if (mem_req && mem_ack) begin
        mem_req       <= 1'b0;
        written_words <= written_words + 1'b1;
      end
    end
  end

  // host word held for the arbiter
  always_ff @(posedge aclk) begin
    if (wr_valid && wr_ready) begin
      mem_wdata <= wr_data;
    end
  end

  a_req_after_ack: assert property (@(posedge aclk) disable iff (!aresetn)
    $rose(mem_req) |-> !mem_ack);

endmodule

/* hw/input_streamer.sv */
`timescale 1ns/100ps

module input_streamer #(
  parameter int CHUNK_WORDS = frame_pkg::DEF_CHUNK_WORDS
) (
  input  logic               aclk,
  input  logic               aresetn,
  input  frame_pkg::count_t  written_words,
  output frame_pkg::word_t   in_data,
  output logic               in_valid,
  input  logic               in_ready,
  output logic               mem_req,
  output logic               mem_we,
  output frame_pkg::addr_t   mem_addr,
  input  logic               mem_ack,
  input  frame_pkg::word_t   mem_rdata
);

  localparam int CW = $clog2(CHUNK_WORDS + 1);

  frame_pkg::count_t rd_ptr;
  logic [CW-1:0]     word_cnt;
  logic              in_chunk;
  logic              chunk_ready;

  // a whole chunk must be written ahead of the read pointer
  assign chunk_ready = (written_words - rd_ptr) >= frame_pkg::count_t'(CHUNK_WORDS);

  assign mem_we   = 1'b0;
  assign mem_addr = frame_pkg::IN_BASE + rd_ptr[7:0];

  // ----------------------------------------
  // chunk and word sequencing
  // ----------------------------------------
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      rd_ptr   <= '0;
      word_cnt <= '0;
      in_chunk <= 1'b0;
      mem_req  <= 1'b0;
      in_valid <= 1'b0;
    end else begin
      if (!in_chunk && chunk_ready) begin
        in_chunk <= 1'b1;
        word_cnt <= '0;
      end
      // next read waits for the stream to drain
      if (in_chunk && !mem_req && !mem_ack && !in_valid) begin
        mem_req <= 1'b1;
      end
      if (mem_req && mem_ack) begin
        mem_req  <= 1'b0;
        in_valid <= 1'b1;
      end
      if (in_valid && in_ready) begin
        in_valid <= 1'b0;
        rd_ptr   <= rd_ptr + 1'b1;
        word_cnt <= word_cnt + 1'b1;
        if (word_cnt == CW'(CHUNK_WORDS - 1)) begin
          in_chunk <= 1'b0;
          word_cnt <= '0;
        end
      end
    end
  end

  always_ff @(posedge aclk) begin
    if (mem_req && mem_ack) begin
      in_data <= mem_rdata;
    end
  end

  a_in_hold: assert property (@(posedge aclk) disable iff (!aresetn)
    in_valid && !in_ready |=> in_valid && $stable(in_data));

endmodule

/* hw/mem_arbiter.sv */
`timescale 1ns/100ps

module mem_arbiter #(
  parameter int N_CLIENTS = frame_pkg::N_CLIENTS
) (
  input  logic                                aclk,
  input  logic                                aresetn,
  input  logic             [N_CLIENTS-1:0]    mem_req,
  input  logic             [N_CLIENTS-1:0]    mem_we,
  input  frame_pkg::addr_t [N_CLIENTS-1:0]    mem_addr,
  input  frame_pkg::word_t [N_CLIENTS-1:0]    mem_wdata,
  output logic             [N_CLIENTS-1:0]    mem_ack,
  output frame_pkg::word_t                    mem_rdata,
  output logic                                ram_en,
  output logic                                ram_we,
  output frame_pkg::addr_t                    ram_addr,
  output frame_pkg::word_t                    ram_wdata,
  input  frame_pkg::word_t                    ram_rdata
);

  localparam int IDX_W = (N_CLIENTS > 1) ? $clog2(N_CLIENTS) : 1;

  typedef enum logic [1:0] {
    IDLE,
    ACCESS,
    ACK
  } state_t;

  state_t           state;
  logic [IDX_W-1:0] last_grant;
  logic [IDX_W-1:0] owner;
  logic [IDX_W-1:0] pick;
  logic             found;

  // ----------------------------------------
  // round robin pick, starting after last grant
  // ----------------------------------------
  always_comb begin
    logic [IDX_W-1:0] cand;
    found = 1'b0;
    pick  = last_grant;
    cand  = last_grant;
    for (int i = 1; i <= N_CLIENTS; i++) begin
      cand = IDX_W'((int'(last_grant) + i) % N_CLIENTS);
      if (!found && mem_req[cand]) begin
        found = 1'b1;
        pick  = cand;
      end
    end
  end

  // memory is accessed on the granting edge
  assign ram_en    = (state == IDLE) && found;
  assign ram_we    = mem_we[pick];
  assign ram_addr  = mem_addr[pick];
  assign ram_wdata = mem_wdata[pick];

  // no new access while ack is up, so read data holds
  assign mem_rdata = ram_rdata;

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      state      <= IDLE;
      owner      <= '0;
      last_grant <= IDX_W'(N_CLIENTS - 1);
      mem_ack    <= '0;
    end else begin
      case (state)
        IDLE: begin
          if (found) begin
            owner      <= pick;
            last_grant <= pick;
            state      <= ACCESS;
          end
        end
        ACCESS: begin
          mem_ack[owner] <= 1'b1;
          state          <= ACK;
        end
        ACK: begin
          // wait for the client to drop req
          if (!mem_req[owner]) begin
            mem_ack <= '0;
            state   <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  a_ack_onehot: assert property (@(posedge aclk) disable iff (!aresetn)
    $onehot0(mem_ack));

  for (genvar g = 0; g < N_CLIENTS; g++) begin : g_ack_chk
    a_ack_to_req: assert property (@(posedge aclk) disable iff (!aresetn)
      $rose(mem_ack[g]) |-> mem_req[g]);
  end

endmodule

/* hw/result_writer.sv */
`timescale 1ns/100ps

module result_writer #(
  parameter int CHUNK_WORDS = frame_pkg::DEF_CHUNK_WORDS,
  parameter int OUT_CHUNKS  = frame_pkg::DEF_OUT_CHUNKS
) (
  input  logic               aclk,
  input  logic               aresetn,
  input  logic               img_buffered,
  input  frame_pkg::word_t   out_data,
  input  logic               out_valid,
  output logic               out_ready,
  output frame_pkg::count_t  stored_words,
  output logic               mem_req,
  output logic               mem_we,
  output frame_pkg::addr_t   mem_addr,
  output frame_pkg::word_t   mem_wdata,
  input  logic               mem_ack
);

  localparam int TOTAL_WORDS = CHUNK_WORDS * OUT_CHUNKS;

  logic run;
  logic last_word;

  assign last_word = stored_words == frame_pkg::count_t'(TOTAL_WORDS - 1);
  assign mem_we    = 1'b1;
  assign mem_addr  = frame_pkg::OUT_BASE + stored_words[7:0];

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      run          <= 1'b0;
      out_ready    <= 1'b0;
      mem_req      <= 1'b0;
      stored_words <= '0;
    end else begin
      // one image per reset, so a finished run never restarts
      if (!run && img_buffered && stored_words == '0) begin
        run <= 1'b1;
      end
      if (out_valid && out_ready) begin
        mem_req   <= 1'b1;
        out_ready <= 1'b0;
      end else if (run && !out_ready && !mem_req && !mem_ack) begin
        out_ready <= 1'b1;
      end
      if (mem_req && mem_ack) begin
        mem_req      <= 1'b0;
        stored_words <= stored_words + 1'b1;
        if (last_word) begin
          run <= 1'b0;
        end
      end
    end
  end

  always_ff @(posedge aclk) begin
    if (out_valid && out_ready) begin
      mem_wdata <= out_data;
    end
  end

  a_no_extra_out: assert property (@(posedge aclk) disable iff (!aresetn)
    out_ready |-> stored_words < frame_pkg::count_t'(TOTAL_WORDS));

endmodule

/* run_sim.sh */
#!/bin/sh
# build and run the frame DMA testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --top-module frame_dma_tb \
  -f frame_dma_top.f -o frame_dma_sim

./obj_dir/frame_dma_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "RESULT: FAIL" sim.log; then
  exit 1
fi
grep -q "RESULT: PASS" sim.log

/* test/frame_dma_cases.txt */
# image length (decimal words), base value (hex), result key (hex), stall flag (0 or 1)
# input word i is base + i, result word i is (base + i) xor key
32 00000000 00000000 0
48 10000000 a5a5a5a5 0
128 00001000 ffffffff 0
40 deadbe00 0f0f0f0f 0
64 12345678 5a5a0000 1
100 0000ff00 00000001 1
16 80000000 c3c3c3c3 0
20 7ffffff0 00ff00ff 0
127 00abcdef 13579bdf 0
96 fffffff8 80000001 1
33 0badf00d 76543210 1
80 00000100 11111111 0
128 55555555 aaaaaaaa 1
8 cafe0000 0000beef 0

/* test/frame_dma_tb.sv */
`timescale 1ns/100ps

module frame_dma_tb;

  localparam int CHUNK_WORDS     = frame_pkg::DEF_CHUNK_WORDS;
  localparam int OUT_CHUNKS      = frame_pkg::DEF_OUT_CHUNKS;
  localparam int RESULT_WORDS    = CHUNK_WORDS * OUT_CHUNKS;
  localparam int QUIET_CYCLES    = 64;
  localparam int CYCLES_PER_WORD = 200;

  logic             aclk;
  logic             aresetn;
  frame_pkg::word_t wr_data;
  logic             wr_valid;
  logic             wr_ready;
  frame_pkg::addr_t rd_addr;
  logic             rd_valid;
  logic             rd_ready;
  frame_pkg::word_t rd_data;
  logic             rd_data_valid;
  frame_pkg::word_t in_data;
  logic             in_valid;
  logic             in_ready;
  frame_pkg::word_t out_data;
  logic             out_valid;
  logic             out_ready;
  logic             img_buffered;

  int               len_q[$];
  frame_pkg::word_t base_q[$];
  frame_pkg::word_t key_q[$];
  bit               stall_q[$];

  int streamed_cnt;
  int accepted_cnt;
  bit case_done;

  frame_dma_top #(
    .CHUNK_WORDS (CHUNK_WORDS),
    .OUT_CHUNKS  (OUT_CHUNKS)
  ) frame_dma_top_i (
    .aclk          (aclk),
    .aresetn       (aresetn),
    .wr_data       (wr_data),
    .wr_valid      (wr_valid),
    .wr_ready      (wr_ready),
    .rd_addr       (rd_addr),
    .rd_valid      (rd_valid),
    .rd_ready      (rd_ready),
    .rd_data       (rd_data),
    .rd_data_valid (rd_data_valid),
    .in_data       (in_data),
    .in_valid      (in_valid),
    .in_ready      (in_ready),
    .out_data      (out_data),
    .out_valid     (out_valid),
    .out_ready     (out_ready),
    .img_buffered  (img_buffered)
  );

  initial begin
    aclk = 1'b0;
    forever #10 aclk = ~aclk;
  end

  // ----------------------------------------
  // helpers
  // ----------------------------------------
  task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                             input string what);
    if (actual !== expected) begin
      $display("[FAIL] %0t: %s, got %h, expected %h", $time, what, actual, expected);
      $display("RESULT: FAIL");
      $fatal(1, "stopped at the first mismatch");
    end
  endtask

  task automatic load_cases(output int total_words);
    int               fd;
    int               n;
    int               len;
    int               stall;
    frame_pkg::word_t base;
    frame_pkg::word_t key;
    string            line;
    total_words = 0;
    fd = $fopen("test/frame_dma_cases.txt", "r");
    if (fd == 0) begin
      $display("could not open test/frame_dma_cases.txt");
      $display("RESULT: FAIL");
      $fatal(1, "no test cases");
    end else begin
      while (!$feof(fd)) begin
        line = "";
        n = $fgets(line, fd);
        // comment and blank lines do not scan as four fields
        if (n > 0 && $sscanf(line, "%d %h %h %d", len, base, key, stall) == 4) begin
          len_q.push_back(len);
          base_q.push_back(base);
          key_q.push_back(key);
          stall_q.push_back(stall != 0);
          total_words += len;
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic watchdog(input int cycles);
    repeat (cycles) @(posedge aclk);
    $display("watchdog expired after %0d cycles, the DUT stopped making progress", cycles);
    $display("RESULT: FAIL");
    $fatal(1, "timeout");
  endtask

  task automatic apply_reset();
    @(negedge aclk);
    aresetn      = 1'b0;
    wr_valid     = 1'b0;
    rd_valid     = 1'b0;
    in_ready     = 1'b0;
    out_valid    = 1'b0;
    img_buffered = 1'b0;
    repeat (4) @(negedge aclk);
    aresetn = 1'b1;
  endtask

  // ----------------------------------------
  // host and accelerator models
  // ----------------------------------------
  task automatic write_image(input int len, input frame_pkg::word_t base);
    int i;
    i = 0;
    while (i < len) begin
      @(negedge aclk);
      wr_valid = 1'b1;
      wr_data  = base + frame_pkg::word_t'(i);
      if (wr_ready) begin
        i++;
      end
    end
    @(negedge aclk);
    wr_valid = 1'b0;
  endtask

  task automatic read_results(input frame_pkg::word_t base, input frame_pkg::word_t key);
    for (int k = 0; k < RESULT_WORDS; k++) begin
      @(negedge aclk);
      rd_valid = 1'b1;
      rd_addr  = frame_pkg::addr_t'(k);
      while (!rd_ready) begin
        @(negedge aclk);
      end
      @(negedge aclk);
      rd_valid = 1'b0;
      while (!rd_data_valid) begin
        @(negedge aclk);
      end
      check_value(rd_data, (base + frame_pkg::word_t'(k)) ^ key, "host read data");
      check_value(32'(accepted_cnt > k), 32'd1, "read returned before its word was stored");
      check_value(32'(img_buffered), 32'd1, "read returned before img_buffered");
    end
  endtask

  // sink for in_data that raises img_buffered once all whole chunks are in
  task automatic accel_input(input int exp_words, input frame_pkg::word_t base,
                             input bit stall);
    while (!case_done) begin
      @(negedge aclk);
      if (streamed_cnt >= exp_words) begin
        img_buffered = 1'b1;
      end
      in_ready = stall ? (($urandom % 4) != 0) : 1'b1;
      if (in_valid && in_ready) begin
        check_value(in_data, base + frame_pkg::word_t'(streamed_cnt), "streamed word");
        streamed_cnt++;
      end
    end
    in_ready = 1'b0;
  endtask

  // offers results from the start and keeps offering past the expected count
  task automatic accel_output(input frame_pkg::word_t base, input frame_pkg::word_t key);
    while (!case_done) begin
      @(negedge aclk);
      out_valid = 1'b1;
      out_data  = (base + frame_pkg::word_t'(accepted_cnt)) ^ key;
      if (out_ready) begin
        check_value(32'(img_buffered), 32'd1, "result accepted before img_buffered");
        accepted_cnt++;
      end
    end
  endtask

  task automatic run_case(input int len, input frame_pkg::word_t base,
                          input frame_pkg::word_t key, input bit stall);
    int exp_words;
    // a trailing partial chunk is never streamed
    exp_words = (len / CHUNK_WORDS) * CHUNK_WORDS;
    apply_reset();
    streamed_cnt = 0;
    accepted_cnt = 0;
    case_done    = 1'b0;
    fork
      begin
        fork
          write_image(len, base);
          read_results(base, key);
        join
        repeat (QUIET_CYCLES) @(negedge aclk);
        case_done = 1'b1;
      end
      accel_input(exp_words, base, stall);
      accel_output(base, key);
    join
    check_value(32'(streamed_cnt), 32'(exp_words), "streamed word count");
    check_value(32'(accepted_cnt), 32'(RESULT_WORDS), "accepted result count");
  endtask

  // ----------------------------------------
  // main sequence
  // ----------------------------------------
  initial begin
    int total_words;
    aresetn      = 1'b0;
    wr_data      = '0;
    wr_valid     = 1'b0;
    rd_addr      = '0;
    rd_valid     = 1'b0;
    in_ready     = 1'b0;
    out_data     = '0;
    out_valid    = 1'b0;
    img_buffered = 1'b0;
    streamed_cnt = 0;
    accepted_cnt = 0;
    case_done    = 1'b0;
    void'($urandom(32'hc869_50b1));
    load_cases(total_words);
    fork
      watchdog(total_words * CYCLES_PER_WORD);
    join_none
    foreach (len_q[c]) begin
      run_case(len_q[c], base_q[c], key_q[c], stall_q[c]);
    end
    if (len_q.size() > 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule
